// File: fe_align.sv
// ==============================
// Align stage of the front end.
// Cuts the queued word stream into 16-bit and 32-bit
// instructions, joining those that cross a word edge.
// ==============================

`timescale 1ns/1ns
`default_nettype none

module fe_align (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  fe_pkg::fetch_word_t word_i,
    input  logic                word_empty_i,
    input  logic                stall_i,
    output logic                word_pop_o,
    output logic                instr_valid_o,
    output fe_pkg::instr_t      instr_o
);

    import fe_pkg::*;

    logic [PARCEL_W-1:0] lo;
    logic [PARCEL_W-1:0] hi;
    addr_t               lo_pc;
    addr_t               hi_pc;
    logic                start_hi;
    logic                active;
    logic                emit;
    logic                pop;
    logic                hold_en;
    instr_t              instr_d;

    logic [PARCEL_W-1:0] hold_q;
    addr_t               hold_pc_q;
    logic                sel_upper_q;
    logic                cross_q;
    logic                instr_valid_q;
    instr_t              instr_q;

    assign lo       = word_i.data[PARCEL_W-1:0];
    assign hi       = word_i.data[XLEN_W-1:PARCEL_W];
    assign lo_pc    = {word_i.addr[XLEN_W-1:2], 2'b00};
    assign hi_pc    = {word_i.addr[XLEN_W-1:2], 2'b10};
    assign start_hi = sel_upper_q | word_i.upper_start;
    assign active   = !word_empty_i & !stall_i;

    // ==============================
    // Parcel selection
    // ==============================

    always_comb begin
        emit    = 1'b0;
        pop     = 1'b0;
        hold_en = 1'b0;
        instr_d = '0;
        if (cross_q) begin
            // Finish a 32-bit instruction with the lower half of this word
            instr_d.pc   = hold_pc_q;
            instr_d.bits = {lo, hold_q};
            emit         = 1'b1;
        end else if (!start_hi) begin
            instr_d.pc = lo_pc;
            emit       = 1'b1;
            if (lo[1:0] != 2'b11) begin
                instr_d.bits       = {{PARCEL_W{1'b0}}, lo};
                instr_d.compressed = 1'b1;
            end else begin
                instr_d.bits = word_i.data;
                pop          = 1'b1;
            end
        end else begin
            pop = 1'b1;
            if (hi[1:0] != 2'b11) begin
                instr_d.pc         = hi_pc;
                instr_d.bits       = {{PARCEL_W{1'b0}}, hi};
                instr_d.compressed = 1'b1;
                emit               = 1'b1;
            end else begin
                // Upper half opens a 32-bit instruction, wait for the next word
                hold_en = 1'b1;
            end
        end
    end

    assign word_pop_o = active & pop;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            instr_valid_q <= 1'b0;
            sel_upper_q   <= 1'b0;
            cross_q       <= 1'b0;
        end else if (!stall_i) begin
            instr_valid_q <= active & emit;
            if (active) begin
                cross_q     <= hold_en;
                // A word not yet popped still has its upper parcel left
                sel_upper_q <= !pop;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (active & emit) begin
            instr_q <= instr_d;
        end
        if (active & hold_en) begin
            hold_q    <= hi;
            hold_pc_q <= hi_pc;
        end
    end

    assign instr_valid_o = instr_valid_q;
    assign instr_o       = instr_q;

endmodule

`default_nettype wire

// File: fe_decode.sv
// ==============================
// Decode stage of the front end.
// Classifies each instruction, extracts register fields
// and sends packets to the back end against credits.
// ==============================

`timescale 1ns/1ns
`default_nettype none

module fe_decode #(
    parameter int CREDITS = 4
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic               instr_valid_i,
    input  fe_pkg::instr_t     instr_i,
    input  logic               credit_return_i,
    output logic               stall_o,
    output logic               packet_valid_o,
    output fe_pkg::fe_packet_t packet_o
);

    import fe_pkg::*;

    localparam int CRD_W = $clog2(CREDITS + 1);

    fe_packet_t       pkt_d;
    logic             q_push;
    logic             q_empty;
    logic             q_full;
    logic             send;
    logic [CRD_W-1:0] credits_q;

    always_comb begin
        pkt_d            = '0;
        pkt_d.pc         = instr_i.pc;
        pkt_d.bits       = instr_i.bits;
        pkt_d.compressed = instr_i.compressed;
        pkt_d.iclass     = CLS_OTHER;
        // Compressed instructions leave unexpanded with zero register fields
        if (!instr_i.compressed) begin
            case (instr_i.bits[6:0])
                OPC_BRANCH: pkt_d.iclass = CLS_BRANCH;
                OPC_JAL:    pkt_d.iclass = CLS_JAL;
                OPC_JALR:   pkt_d.iclass = CLS_JALR;
                default:    pkt_d.iclass = CLS_OTHER;
            endcase
            pkt_d.rd  = instr_i.bits[7 +: REG_ADDR_W];
            pkt_d.rs1 = instr_i.bits[15 +: REG_ADDR_W];
            pkt_d.rs2 = instr_i.bits[20 +: REG_ADDR_W];
        end
    end

    assign q_push  = instr_valid_i & !q_full;
    assign stall_o = q_full;

    fe_queue #(
        .payload_t (fe_packet_t),
        .DEPTH     (CREDITS)
    ) u_packet_queue (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .push_i  (q_push),
        .data_i  (pkt_d),
        .pop_i   (send),
        .data_o  (packet_o),
        .empty_o (q_empty),
        .full_o  (q_full)
    );

    // ==============================
    // Back-end credits
    // ==============================

    assign send           = !q_empty & (credits_q != '0);
    assign packet_valid_o = send;

    // Redirects leave the count alone since sent packets stay owned by the back end
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credits_q <= CRD_W'(CREDITS);
        end else begin
            credits_q <= credits_q - CRD_W'(send) + CRD_W'(credit_return_i);
        end
    end

    a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credits_q <= CRD_W'(CREDITS))
        else $error("credit count %0d above limit", credits_q);

    a_credit_return : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_return_i |-> credits_q != CRD_W'(CREDITS))
        else $error("credit returned with no packet outstanding");

endmodule

`default_nettype wire

// File: fe_pc_gen.sv
// ==============================
// Program counter and fetch request generation.
// Resolves exception over branch redirect, throttles
// requests against the word queue depth and tags
// each fetched word for the align stage.
// ==============================

`timescale 1ns/1ns
`default_nettype none

module fe_pc_gen #(
    parameter fe_pkg::addr_t RESET_PC         = '0,
    parameter int            WORD_QUEUE_DEPTH = 4
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                exception_i,
    input  fe_pkg::addr_t       handler_pc_i,
    input  logic                redirect_i,
    input  fe_pkg::addr_t       redirect_pc_i,
    input  logic                word_pop_i,
    output logic                fetch_req_o,
    output fe_pkg::addr_t       fetch_addr_o,
    output fe_pkg::fetch_word_t fetch_tag_o,
    output logic                flush_o
);

    import fe_pkg::*;

    localparam int CNT_W = $clog2(WORD_QUEUE_DEPTH + 1);

    addr_t            pc_q;
    logic             upper_q;
    logic             run_q;
    logic [CNT_W-1:0] words_q;
    addr_t            tag_addr_q;
    logic             tag_upper_q;
    addr_t            target;

    // ==============================
    // Redirect priority
    // ==============================

    assign flush_o = exception_i | redirect_i;
    assign target  = exception_i ? handler_pc_i : redirect_pc_i;

    // Words in flight plus words queued never exceed the queue depth
    assign fetch_req_o  = run_q & !flush_o & (words_q < CNT_W'(WORD_QUEUE_DEPTH));
    assign fetch_addr_o = pc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q    <= {RESET_PC[XLEN_W-1:2], 2'b00};
            upper_q <= RESET_PC[1];
            run_q   <= 1'b0;
            words_q <= '0;
        end else begin
            run_q <= 1'b1;
            if (flush_o) begin
                // Queue and in-flight response are both dropped by the flush
                pc_q    <= {target[XLEN_W-1:2], 2'b00};
                upper_q <= target[1];
                words_q <= '0;
            end else begin
                words_q <= words_q + CNT_W'(fetch_req_o) - CNT_W'(word_pop_i);
                if (fetch_req_o) begin
                    pc_q    <= pc_q + XLEN_W'(4);
                    upper_q <= 1'b0;
                end
            end
        end
    end

    // Tag for the response that arrives one cycle after the request
    always_ff @(posedge clk_i) begin
        if (fetch_req_o) begin
            tag_addr_q  <= {pc_q[XLEN_W-1:2], upper_q, 1'b0};
            tag_upper_q <= upper_q;
        end
    end

    assign fetch_tag_o = fetch_word_t'{
        data:        '0,
        addr:        tag_addr_q,
        upper_start: tag_upper_q
    };

    // Without the C extension odd targets would be legal to trap on, here they are not
    a_target_aligned : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_o |-> !target[0])
        else $error("redirect target %h is not halfword aligned", target);

endmodule

`default_nettype wire

// File: fe_pkg.sv
// ==============================
// Shared definitions of the instruction front end.
// Holds the widths, the stage payload structs and the
// classification codes. Modules import it in their bodies.
// ==============================

`default_nettype none

package fe_pkg;

    localparam int XLEN_W     = 32;
    localparam int PARCEL_W   = 16;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN_W-1:0] addr_t;

    // One fetched word, tagged with the address of its first useful parcel
    typedef struct packed {
        logic [XLEN_W-1:0] data;
        addr_t             addr;
        logic              upper_start;
    } fetch_word_t;

    // Compressed instructions keep the upper half of bits at zero
    typedef struct packed {
        addr_t             pc;
        logic [XLEN_W-1:0] bits;
        logic              compressed;
    } instr_t;

    typedef enum logic [1:0] {
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_OTHER
    } instr_class_t;

    typedef struct packed {
        addr_t                 pc;
        logic [XLEN_W-1:0]     bits;
        logic                  compressed;
        instr_class_t          iclass;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
    } fe_packet_t;

    // ==============================
    // Major opcodes
    // ==============================

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

`default_nettype wire

// File: fe_queue.sv
// ==============================
// Synchronous FIFO with a payload type parameter.
// Holds fetched words ahead of the align stage and
// decoded packets waiting for back-end credits.
// ==============================

`timescale 1ns/1ns
`default_nettype none

module fe_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             empty_q;
    logic             full_q;

    // DEPTH need not be a power of two, so wrap explicitly
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign count_d = count_q + CNT_W'(push_i) - CNT_W'(pop_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            empty_q  <= 1'b1;
            full_q   <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_d;
            empty_q <= (count_d == '0);
            full_q  <= (count_d == CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    assign data_o  = mem_q[rd_ptr_q];
    assign empty_o = empty_q;
    assign full_o  = full_q;

    // Producers are expected to throttle themselves on the registered flags
    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        push_i |-> !full_q)
        else $error("fe_queue push while full");

    a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        pop_i |-> !empty_q)
        else $error("fe_queue pop while empty");

endmodule

`default_nettype wire

// File: fe_top.sv
// ==============================
// Top level of the instruction front end.
// Chains PC generation, the word queue, align and
// decode between the memory port and the back end.
// ==============================

`timescale 1ns/1ns
`default_nettype none

module fe_top #(
    parameter fe_pkg::addr_t RESET_PC         = '0,
    parameter int            WORD_QUEUE_DEPTH = 4,
    parameter int            CREDITS          = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    output logic                        fetch_req_o,
    output fe_pkg::addr_t               fetch_addr_o,
    input  logic                        fetch_valid_i,
    input  logic [fe_pkg::XLEN_W-1:0]   fetch_data_i,
    input  logic                        exception_i,
    input  fe_pkg::addr_t               handler_pc_i,
    input  logic                        redirect_i,
    input  fe_pkg::addr_t               redirect_pc_i,
    input  logic                        credit_return_i,
    output logic                        packet_valid_o,
    output fe_pkg::fe_packet_t          packet_o
);

    import fe_pkg::*;

    logic        flush;
    logic        word_push;
    logic        word_pop;
    logic        word_empty;
    logic        instr_valid;
    logic        dec_stall;
    fetch_word_t fetch_tag;
    fetch_word_t fetch_word;
    fetch_word_t word_head;
    instr_t      instr;

    fe_pc_gen #(
        .RESET_PC         (RESET_PC),
        .WORD_QUEUE_DEPTH (WORD_QUEUE_DEPTH)
    ) u_pc_gen (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .exception_i   (exception_i),
        .handler_pc_i  (handler_pc_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .word_pop_i    (word_pop),
        .fetch_req_o   (fetch_req_o),
        .fetch_addr_o  (fetch_addr_o),
        .fetch_tag_o   (fetch_tag),
        .flush_o       (flush)
    );

    // The response in flight during a flush belongs to the old stream
    assign word_push  = fetch_valid_i & !flush;
    assign fetch_word = fetch_word_t'{
        data:        fetch_data_i,
        addr:        fetch_tag.addr,
        upper_start: fetch_tag.upper_start
    };

    fe_queue #(
        .payload_t (fetch_word_t),
        .DEPTH     (WORD_QUEUE_DEPTH)
    ) u_word_queue (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush),
        .push_i  (word_push),
        .data_i  (fetch_word),
        .pop_i   (word_pop),
        .data_o  (word_head),
        .empty_o (word_empty),
        .full_o  ()
    );

    fe_align u_align (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush),
        .word_i        (word_head),
        .word_empty_i  (word_empty),
        .stall_i       (dec_stall),
        .word_pop_o    (word_pop),
        .instr_valid_o (instr_valid),
        .instr_o       (instr)
    );

    fe_decode #(
        .CREDITS (CREDITS)
    ) u_decode (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush),
        .instr_valid_i   (instr_valid),
        .instr_i         (instr),
        .credit_return_i (credit_return_i),
        .stall_o         (dec_stall),
        .packet_valid_o  (packet_valid_o),
        .packet_o        (packet_o)
    );

endmodule

`default_nettype wire

// File: files.f
fe_pkg.sv
fe_queue.sv
fe_pc_gen.sv
fe_align.sv
fe_decode.sv
fe_top.sv
tb_clock_gen.sv
tb_fe_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the front-end testbench with Verilator and runs it.
# Exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_fe_top \
    -f files.f -o tb_fe_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fe_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
exit 1

// File: tb_clock_gen.sv
// ==============================
// Testbench clock and reset source.
// Free-running clock, reset held low for a number of cycles.
// ==============================

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_fe_input.txt
// Per test: name(ascii) nwords base redir_cycle redir_target exc_cycle exc_target
// credit_mode(0 always, 1 random), then nwords memory words. A zero name ends the list.
// 32-bit instructions from the reset address, all classes
73657131 00000006 00000000 00000000 00000000 00000000 00000000 00000000
00500093 00208133 00c58663 008000ef 000080e7 40315233
// Mixed compressed code with word-crossing 32-bit instructions
6d697832 00000008 00000100 00000000 00000000 00000000 00000000 00000001
00934505 05050050 86638082 000100c5 008000ef 00014501 40315233 000080e7
// Redirect onto an upper halfword
72656472 00000006 00000200 00000006 0000020a 00000000 00000000 00000000
00500093 00a00113 86630001 050500c5 00208133 0000006f
// Exception and redirect in the same cycle
65786370 00000006 00000300 00000005 00000304 00000005 00000312 00000001
00100093 00200113 00300193 00400213 00e74505 00010000
// Back-pressure from sparse credit returns
6261636b 00000008 00000400 00000000 00000000 00000000 00000000 00000001
00c58663 0000006f 000080e7 40315233 45054501 80820505 00500093 00208133
00000000

// File: tb_fe_top.sv
// ==============================
// Testbench of the instruction front end.
// Reads tests from tb_fe_input.txt, answers fetches with a
// one-cycle memory, returns credits and checks every packet
// against a reference walk of the memory image.
// ==============================

`timescale 1ns/1ns
`default_nettype none

module tb_fe_top;

    import fe_pkg::*;

    localparam int    CREDITS         = 4;
    localparam addr_t RESET_PC        = '0;
    localparam int    MAX_TESTS       = 8;
    localparam int    STIM_WORDS      = 256;
    localparam int    HEADER_WORDS    = 8;
    localparam int    CYCLE_NS        = 8;
    localparam int    RESET_CYCLES    = 16;
    localparam int    CYCLES_PER_WORD = 40;

    // Major opcodes that carry their own class
    localparam logic [6:0] BRANCH_OP = 7'b1100011;
    localparam logic [6:0] JAL_OP    = 7'b1101111;
    localparam logic [6:0] JALR_OP   = 7'b1100111;

    logic        clk;
    logic        rst_n;
    logic        fetch_req;
    addr_t       fetch_addr;
    logic        fetch_valid;
    logic [31:0] fetch_data;
    logic        exception;
    addr_t       handler_pc;
    logic        redirect;
    addr_t       redirect_pc;
    logic        credit_return;
    logic        packet_valid;
    fe_packet_t  packet;

    logic [31:0] stim [STIM_WORDS];
    logic [31:0] t_name [MAX_TESTS];
    logic [31:0] t_nwords [MAX_TESTS];
    logic [31:0] t_base [MAX_TESTS];
    logic [31:0] t_off [MAX_TESTS];
    logic [31:0] t_rcyc [MAX_TESTS];
    logic [31:0] t_rtgt [MAX_TESTS];
    logic [31:0] t_xcyc [MAX_TESTS];
    logic [31:0] t_xtgt [MAX_TESTS];
    logic [31:0] t_mode [MAX_TESTS];

    int         num_tests;
    int         total_words;
    int         cur_t;
    logic [31:0] cur_mode;
    int         outstanding;
    int         errors;
    int         checks;
    int         tests_failed;
    bit         loaded;
    integer     seed;
    addr_t      fetch_tgt;
    addr_t      next_fetch;
    fe_packet_t exp_q [$];

    tb_clock_gen #(
        .PERIOD_NS    (CYCLE_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fe_top fe_top_inst (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .fetch_req_o     (fetch_req),
        .fetch_addr_o    (fetch_addr),
        .fetch_valid_i   (fetch_valid),
        .fetch_data_i    (fetch_data),
        .exception_i     (exception),
        .handler_pc_i    (handler_pc),
        .redirect_i      (redirect),
        .redirect_pc_i   (redirect_pc),
        .credit_return_i (credit_return),
        .packet_valid_o  (packet_valid),
        .packet_o        (packet)
    );

    // ==============================
    // Memory image and reference walk
    // ==============================

    // Outside the image every word is a 32-bit OP-IMM built from its address
    function automatic logic [31:0] mem_word(input int t, input addr_t addr);
        addr_t wa;
        wa = {addr[31:2], 2'b00};
        if (wa >= t_base[t] && wa < t_base[t] + 4 * t_nwords[t]) begin
            return stim[t_off[t] + ((wa - t_base[t]) >> 2)];
        end
        return {wa[31:7] ^ {20'b0, wa[6:2]}, 7'b0010011};
    endfunction

    function automatic logic [15:0] parcel_at(input int t, input addr_t addr);
        logic [31:0] w;
        w = mem_word(t, addr);
        return addr[1] ? w[31:16] : w[15:0];
    endfunction

    function automatic fe_packet_t expect_packet(input addr_t pc, input logic [31:0] bits,
                                                 input logic comp);
        fe_packet_t p;
        p            = '0;
        p.pc         = pc;
        p.bits       = bits;
        p.compressed = comp;
        p.iclass     = CLS_OTHER;
        if (!comp) begin
            if (bits[6:0] == BRANCH_OP) p.iclass = CLS_BRANCH;
            if (bits[6:0] == JAL_OP) p.iclass = CLS_JAL;
            if (bits[6:0] == JALR_OP) p.iclass = CLS_JALR;
            p.rd  = bits[11:7];
            p.rs1 = bits[19:15];
            p.rs2 = bits[24:20];
        end
        return p;
    endfunction

    // Every instruction that starts inside the image at or after the start address
    task automatic build_expected(input int t, input addr_t start);
        addr_t       pc;
        addr_t       stop;
        logic [15:0] lo;
        logic [15:0] hi;
        exp_q.delete();
        pc   = start;
        stop = t_base[t] + 4 * t_nwords[t];
        while (pc < stop) begin
            lo = parcel_at(t, pc);
            if (lo[1:0] == 2'b11) begin
                hi = parcel_at(t, pc + 2);
                exp_q.push_back(expect_packet(pc, {hi, lo}, 1'b0));
                pc = pc + 4;
            end else begin
                exp_q.push_back(expect_packet(pc, {16'h0, lo}, 1'b1));
                pc = pc + 2;
            end
        end
    endtask

    task automatic load_tests();
        int p;
        $readmemh("tb_fe_input.txt", stim);
        p = 0;
        while (p + HEADER_WORDS <= STIM_WORDS && num_tests < MAX_TESTS
               && !$isunknown(stim[p]) && stim[p] != 32'h0) begin
            t_name[num_tests]   = stim[p];
            t_nwords[num_tests] = stim[p + 1];
            t_base[num_tests]   = stim[p + 2];
            t_rcyc[num_tests]   = stim[p + 3];
            t_rtgt[num_tests]   = stim[p + 4];
            t_xcyc[num_tests]   = stim[p + 5];
            t_xtgt[num_tests]   = stim[p + 6];
            t_mode[num_tests]   = stim[p + 7];
            t_off[num_tests]    = p + HEADER_WORDS;
            total_words         = total_words + int'(stim[p + 1]);
            p                   = p + HEADER_WORDS + int'(stim[p + 1]);
            num_tests           = num_tests + 1;
        end
    endtask

    // ==============================
    // Memory and back-end models
    // ==============================

    // Requests step one word at a time and restart at the target word after a redirect
    always @(posedge clk) begin
        if (!rst_n) begin
            assert (fetch_req !== 1'b1 && packet_valid !== 1'b1)
                else begin
                    $display("fetch request or packet raised during reset");
                    errors = errors + 1;
                end
            fetch_valid <= 1'b0;
            next_fetch  <= RESET_PC;
        end else begin
            if (redirect || exception) begin
                next_fetch <= {fetch_tgt[31:2], 2'b00};
            end else if (fetch_req) begin
                checks = checks + 1;
                assert (fetch_addr === next_fetch)
                    else begin
                        $display("error %s: fetch address expected %h actual %h",
                                 t_name[cur_t], next_fetch, fetch_addr);
                        errors = errors + 1;
                    end
                next_fetch <= next_fetch + 32'd4;
            end
            fetch_valid <= fetch_req;
            fetch_data  <= mem_word(cur_t, fetch_addr);
        end
    end

    always @(posedge clk) begin : credit_model
        int          pending;
        logic [31:0] rnd;
        rnd = $random(seed);
        if (rst_n) begin
            pending = outstanding + (packet_valid ? 1 : 0) - (credit_return ? 1 : 0);
            checks  = checks + 1;
            assert (pending <= CREDITS)
                else begin
                    $display("more than %0d packets sent without returned credits", CREDITS);
                    errors = errors + 1;
                end
            outstanding   <= pending;
            credit_return <= (pending > 0) && (cur_mode == 0 || rnd[0]);
        end
    end

    // ==============================
    // Test sequencing
    // ==============================

    task automatic run_test(input int t);
        int    cyc;
        int    idx;
        int    errs_before;
        bit    pend;
        bit    done;
        addr_t tgt;
        errs_before = errors;
        cur_t    <= t;
        cur_mode <= t_mode[t];
        cyc  = 0;
        idx  = 0;
        pend = 1'b0;
        done = 1'b0;
        tgt  = t_base[t];
        if (t == 0) begin
            build_expected(t, t_base[t]);
        end else begin
            @(posedge clk);
            redirect    <= 1'b1;
            redirect_pc <= t_base[t];
            fetch_tgt   <= t_base[t];
            pend = 1'b1;
        end
        while (!done) begin
            @(posedge clk);
            cyc = cyc + 1;
            if (pend) begin
                // A packet sent in the redirect cycle still belongs to the old stream
                pend = 1'b0;
                build_expected(t, tgt);
                idx = 0;
            end else if (packet_valid && idx < exp_q.size()) begin
                checks = checks + 1;
                assert (packet === exp_q[idx])
                    else begin
                        $display("error %s: packet %0d expected %h actual %h",
                                 t_name[t], idx, exp_q[idx], packet);
                        errors = errors + 1;
                    end
                idx = idx + 1;
            end
            redirect  <= 1'b0;
            exception <= 1'b0;
            if (t_rcyc[t] != 0 && cyc == t_rcyc[t]) begin
                redirect    <= 1'b1;
                redirect_pc <= t_rtgt[t];
                fetch_tgt   <= t_rtgt[t];
                pend = 1'b1;
                tgt  = t_rtgt[t];
            end
            // Exception wins when both land in the same cycle
            if (t_xcyc[t] != 0 && cyc == t_xcyc[t]) begin
                exception  <= 1'b1;
                handler_pc <= t_xtgt[t];
                fetch_tgt  <= t_xtgt[t];
                pend = 1'b1;
                tgt  = t_xtgt[t];
            end
            done = !pend && idx == exp_q.size() && cyc >= t_rcyc[t] && cyc >= t_xcyc[t];
        end
        if (errors == errs_before) begin
            $display("test %s ok, %0d packets", t_name[t], idx);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s failed with %0d errors", t_name[t], errors - errs_before);
        end
    endtask

    initial begin
        seed          = 32'h23d4_55d8;
        fetch_valid   = 1'b0;
        fetch_data    = '0;
        exception     = 1'b0;
        handler_pc    = '0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        credit_return = 1'b0;
        fetch_tgt     = '0;
        next_fetch    = RESET_PC;
        cur_t         = 0;
        cur_mode      = '0;
        outstanding   = 0;
        errors        = 0;
        checks        = 0;
        tests_failed  = 0;
        num_tests     = 0;
        total_words   = 0;
        load_tests();
        loaded = 1'b1;
        if (num_tests == 0) begin
            $display("no tests found in the input file");
            errors = errors + 1;
        end
        wait (rst_n === 1'b1);
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 num_tests, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Budget grows with the size of the memory images
    initial begin : watchdog
        wait (loaded);
        repeat (total_words * CYCLES_PER_WORD + RESET_CYCLES + 64) @(posedge clk);
        $display("timeout: packets stopped arriving before all tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
